/* Makefile */
VERILATOR ?= verilator
TOP       ?= axi3_mem_tb
FILELIST  ?= axi3_mem_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
RUN_ARGS  ?= +verilator+error+limit+100
PASS_MSG  := RESULT: PASS

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	-./$(SIM_BIN) $(RUN_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* axi3_mem/axi3_mem_array.sv */
`timescale 1ns/1ps
`default_nettype none

module axi3_mem_array #(
    parameter int DATA_BYTE_WID = 8,
    parameter int ID_WID = 4,
    parameter int MEM_WORDS_LOG2 = 10
) (
    input  wire                          axi3_if,
    input  wire                          srst,
    input  wire                          mem_we,
    input  wire [MEM_WORDS_LOG2-1:0]     mem_waddr,
    input  wire [DATA_BYTE_WID*8-1:0]    mem_wdata,
    input  wire [DATA_BYTE_WID-1:0]      mem_wstrb,
    input  wire                          mem_re,
    input  wire [MEM_WORDS_LOG2-1:0]     mem_raddr,
    input  wire [ID_WID-1:0]             rd_id,
    input  wire                          rd_last,
    output logic                         rd_valid,
    output logic [DATA_BYTE_WID*8-1:0]   rd_data,
    output logic [ID_WID-1:0]            rd_id_q,
    output logic                         rd_last_q
);

    logic [DATA_BYTE_WID*8-1:0] ram [2**MEM_WORDS_LOG2];

    // Byte lanes written only where the strobe is set
    always_ff @(posedge axi3_if) begin
        if (mem_we) begin
            for (int i = 0; i < DATA_BYTE_WID; i++) begin
                if (mem_wstrb[i]) begin
                    ram[mem_waddr][i*8 +: 8] <= mem_wdata[i*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge axi3_if) begin
        if (mem_re) begin
            rd_data <= ram[mem_raddr];
            rd_id_q <= rd_id;
            rd_last_q <= rd_last;
        end
    end

    always_ff @(posedge axi3_if) begin
        if (srst) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= mem_re;
        end
    end

endmodule : axi3_mem_array

`default_nettype wire

/* axi3_mem/axi3_mem_rd_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module axi3_mem_rd_stage #(
    parameter int ADDR_WID = 16,
    parameter int DATA_BYTE_WID = 8,
    parameter int ID_WID = 4,
    parameter int MEM_WORDS_LOG2 = 10
) (
    input  wire                          axi3_if,
    input  wire                          srst,
    input  wire                          arvalid,
    output logic                         arready,
    input  wire [ADDR_WID-1:0]           araddr,
    input  wire axi3_pkg::len_t          arlen,
    input  wire [ID_WID-1:0]             arid,
    input  wire                          r_room,
    output logic                         mem_re,
    output logic [MEM_WORDS_LOG2-1:0]    mem_raddr,
    output logic [ID_WID-1:0]            rd_id,
    output logic                         rd_last
);

    localparam int BYTE_SEL_WID = $clog2(DATA_BYTE_WID);
    localparam int PTR_WID = $clog2(axi3_pkg::ADDR_Q_DEPTH);
    localparam int CNT_WID = $clog2(axi3_pkg::ADDR_Q_DEPTH + 1);

    logic [MEM_WORDS_LOG2-1:0] ar_q_addr [axi3_pkg::ADDR_Q_DEPTH];
    logic [ID_WID-1:0]         ar_q_id [axi3_pkg::ADDR_Q_DEPTH];
    axi3_pkg::len_t            ar_q_len [axi3_pkg::ADDR_Q_DEPTH];
    logic [PTR_WID-1:0]        ar_wr_ptr;
    logic [PTR_WID-1:0]        ar_rd_ptr;
    logic [CNT_WID-1:0]        ar_count;
    logic                      ar_push;
    logic                      ar_pop;

    logic                      busy;
    logic [MEM_WORDS_LOG2-1:0] cur_addr;
    logic [ID_WID-1:0]         cur_id;
    axi3_pkg::len_t            beats_left;
    logic                      issue;
    logic                      issue_last;

    assign arready = (ar_count != CNT_WID'(axi3_pkg::ADDR_Q_DEPTH));
    assign ar_push = arvalid && arready;

    assign issue = busy && r_room;
    assign issue_last = issue && (beats_left == '0);
    // Next burst is loaded while the final beat of the current one issues
    assign ar_pop = (ar_count != '0) && (!busy || issue_last);

    always_ff @(posedge axi3_if) begin
        if (ar_push) begin
            ar_q_addr[ar_wr_ptr] <= araddr[BYTE_SEL_WID +: MEM_WORDS_LOG2];
            ar_q_id[ar_wr_ptr] <= arid;
            ar_q_len[ar_wr_ptr] <= arlen;
        end
    end

    always_ff @(posedge axi3_if) begin
        if (srst) begin
            ar_wr_ptr <= '0;
            ar_rd_ptr <= '0;
            ar_count <= '0;
            busy <= 1'b0;
            mem_re <= 1'b0;
        end else begin
            if (ar_push) begin
                ar_wr_ptr <= ar_wr_ptr + 1'b1;
            end
            if (ar_pop) begin
                ar_rd_ptr <= ar_rd_ptr + 1'b1;
            end
            ar_count <= ar_count + CNT_WID'(ar_push) - CNT_WID'(ar_pop);
            mem_re <= issue;
            if (ar_pop) begin
                busy <= 1'b1;
            end else if (issue_last) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge axi3_if) begin
        if (ar_pop) begin
            cur_addr <= ar_q_addr[ar_rd_ptr];
            cur_id <= ar_q_id[ar_rd_ptr];
            beats_left <= ar_q_len[ar_rd_ptr];
        end else if (issue) begin
            cur_addr <= cur_addr + 1'b1;
            beats_left <= beats_left - 1'b1;
        end
        if (issue) begin
            mem_raddr <= cur_addr;
            rd_id <= cur_id;
            rd_last <= (beats_left == '0);
        end
    end

endmodule : axi3_mem_rd_stage

`default_nettype wire

/* axi3_mem/axi3_mem_resp_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module axi3_mem_resp_stage #(
    parameter int DATA_BYTE_WID = 8,
    parameter int ID_WID = 4
) (
    input  wire                          axi3_if,
    input  wire                          srst,
    input  wire                          wr_done,
    input  wire [ID_WID-1:0]             wr_id,
    input  wire                          rd_valid,
    input  wire [DATA_BYTE_WID*8-1:0]    rd_data,
    input  wire [ID_WID-1:0]             rd_id_q,
    input  wire                          rd_last_q,
    output logic                         b_room,
    output logic                         r_room,
    output logic                         bvalid,
    input  wire                          bready,
    output logic [ID_WID-1:0]            bid,
    output axi3_pkg::resp_t              bresp,
    output logic                         rvalid,
    input  wire                          rready,
    output logic [DATA_BYTE_WID*8-1:0]   rdata,
    output logic [ID_WID-1:0]            rid,
    output logic                         rlast,
    output axi3_pkg::resp_t              rresp
);

    localparam int DEPTH = axi3_pkg::RESP_Q_DEPTH;
    localparam int PTR_WID = $clog2(DEPTH);
    localparam int CNT_WID = $clog2(DEPTH + 1);

    logic [ID_WID-1:0]          b_q_id [DEPTH];
    logic [PTR_WID-1:0]         b_wr_ptr;
    logic [PTR_WID-1:0]         b_rd_ptr;
    logic [CNT_WID-1:0]         b_count;
    logic                       b_pop;

    logic [DATA_BYTE_WID*8-1:0] r_q_data [DEPTH];
    logic [ID_WID-1:0]          r_q_id [DEPTH];
    logic                       r_q_last [DEPTH];
    logic [PTR_WID-1:0]         r_wr_ptr;
    logic [PTR_WID-1:0]         r_rd_ptr;
    logic [CNT_WID-1:0]         r_count;
    logic                       r_pop;

    // A pending wr_done already claims its entry
    assign b_room = (b_count + CNT_WID'(wr_done)) < CNT_WID'(DEPTH);
    // Two free beyond the beat leaving the array, for the one still in the RAM read
    assign r_room = (r_count + CNT_WID'(rd_valid)) <= CNT_WID'(DEPTH - 2);

    assign bvalid = (b_count != '0);
    assign bid = b_q_id[b_rd_ptr];
    assign bresp = axi3_pkg::RESP_OKAY;
    assign b_pop = bvalid && bready;

    assign rvalid = (r_count != '0);
    assign rdata = r_q_data[r_rd_ptr];
    assign rid = r_q_id[r_rd_ptr];
    assign rlast = r_q_last[r_rd_ptr];
    assign rresp = axi3_pkg::RESP_OKAY;
    assign r_pop = rvalid && rready;

    always_ff @(posedge axi3_if) begin
        if (wr_done) begin
            b_q_id[b_wr_ptr] <= wr_id;
        end
        if (rd_valid) begin
            r_q_data[r_wr_ptr] <= rd_data;
            r_q_id[r_wr_ptr] <= rd_id_q;
            r_q_last[r_wr_ptr] <= rd_last_q;
        end
    end

    always_ff @(posedge axi3_if) begin
        if (srst) begin
            b_wr_ptr <= '0;
            b_rd_ptr <= '0;
            b_count <= '0;
            r_wr_ptr <= '0;
            r_rd_ptr <= '0;
            r_count <= '0;
        end else begin
            if (wr_done) begin
                b_wr_ptr <= b_wr_ptr + 1'b1;
            end
            if (b_pop) begin
                b_rd_ptr <= b_rd_ptr + 1'b1;
            end
            b_count <= b_count + CNT_WID'(wr_done) - CNT_WID'(b_pop);
            if (rd_valid) begin
                r_wr_ptr <= r_wr_ptr + 1'b1;
            end
            if (r_pop) begin
                r_rd_ptr <= r_rd_ptr + 1'b1;
            end
            r_count <= r_count + CNT_WID'(rd_valid) - CNT_WID'(r_pop);
        end
    end

endmodule : axi3_mem_resp_stage

`default_nettype wire

/* axi3_mem/axi3_mem_wr_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module axi3_mem_wr_stage #(
    parameter int ADDR_WID = 16,
    parameter int DATA_BYTE_WID = 8,
    parameter int ID_WID = 4,
    parameter int MEM_WORDS_LOG2 = 10
) (
    input  wire                          axi3_if,
    input  wire                          srst,
    input  wire                          awvalid,
    output logic                         awready,
    input  wire [ADDR_WID-1:0]           awaddr,
    input  wire axi3_pkg::len_t          awlen,
    input  wire [ID_WID-1:0]             awid,
    input  wire                          wvalid,
    output logic                         wready,
    input  wire [DATA_BYTE_WID*8-1:0]    wdata,
    input  wire [DATA_BYTE_WID-1:0]      wstrb,
    input  wire                          wlast,
    input  wire                          b_room,
    output logic                         mem_we,
    output logic [MEM_WORDS_LOG2-1:0]    mem_waddr,
    output logic [DATA_BYTE_WID*8-1:0]   mem_wdata,
    output logic [DATA_BYTE_WID-1:0]     mem_wstrb,
    output logic                         wr_done,
    output logic [ID_WID-1:0]            wr_id
);

    localparam int BYTE_SEL_WID = $clog2(DATA_BYTE_WID);
    localparam int PTR_WID = $clog2(axi3_pkg::ADDR_Q_DEPTH);
    localparam int CNT_WID = $clog2(axi3_pkg::ADDR_Q_DEPTH + 1);

    logic [MEM_WORDS_LOG2-1:0] aw_q_addr [axi3_pkg::ADDR_Q_DEPTH];
    logic [ID_WID-1:0]         aw_q_id [axi3_pkg::ADDR_Q_DEPTH];
    axi3_pkg::len_t            aw_q_len [axi3_pkg::ADDR_Q_DEPTH];
    logic [PTR_WID-1:0]        aw_wr_ptr;
    logic [PTR_WID-1:0]        aw_rd_ptr;
    logic [CNT_WID-1:0]        aw_count;
    logic                      aw_push;
    logic                      aw_pop;

    axi3_pkg::wr_state_t       state;
    logic [MEM_WORDS_LOG2-1:0] cur_addr;
    logic [ID_WID-1:0]         cur_id;
    axi3_pkg::len_t            beats_left;
    logic                      last_beat;
    logic                      w_fire;

    assign awready = (aw_count != CNT_WID'(axi3_pkg::ADDR_Q_DEPTH));
    assign aw_push = awvalid && awready;
    assign aw_pop = (state == axi3_pkg::WR_IDLE) && (aw_count != '0);

    // Last beat may only go when the B FIFO can take its response
    assign last_beat = wlast || (beats_left == '0);
    assign wready = (state == axi3_pkg::WR_BURST) && (b_room || !last_beat);
    assign w_fire = wvalid && wready;

    always_ff @(posedge axi3_if) begin
        if (aw_push) begin
            aw_q_addr[aw_wr_ptr] <= awaddr[BYTE_SEL_WID +: MEM_WORDS_LOG2];
            aw_q_id[aw_wr_ptr] <= awid;
            aw_q_len[aw_wr_ptr] <= awlen;
        end
    end

    always_ff @(posedge axi3_if) begin
        if (srst) begin
            aw_wr_ptr <= '0;
            aw_rd_ptr <= '0;
            aw_count <= '0;
        end else begin
            if (aw_push) begin
                aw_wr_ptr <= aw_wr_ptr + 1'b1;
            end
            if (aw_pop) begin
                aw_rd_ptr <= aw_rd_ptr + 1'b1;
            end
            aw_count <= aw_count + CNT_WID'(aw_push) - CNT_WID'(aw_pop);
        end
    end

    always_ff @(posedge axi3_if) begin
        if (srst) begin
            state <= axi3_pkg::WR_IDLE;
            mem_we <= 1'b0;
            wr_done <= 1'b0;
        end else begin
            mem_we <= w_fire;
            wr_done <= w_fire && last_beat;
            case (state)
                axi3_pkg::WR_IDLE: begin
                    if (aw_pop) begin
                        state <= axi3_pkg::WR_BURST;
                    end
                end
                axi3_pkg::WR_BURST: begin
                    if (w_fire && last_beat) begin
                        state <= axi3_pkg::WR_IDLE;
                    end
                end
                default: state <= axi3_pkg::WR_IDLE;
            endcase
        end
    end

    // Burst context and the registered RAM write
    always_ff @(posedge axi3_if) begin
        if (aw_pop) begin
            cur_addr <= aw_q_addr[aw_rd_ptr];
            cur_id <= aw_q_id[aw_rd_ptr];
            beats_left <= aw_q_len[aw_rd_ptr];
        end else if (w_fire) begin
            cur_addr <= cur_addr + 1'b1;
            beats_left <= beats_left - 1'b1;
        end
        if (w_fire) begin
            mem_waddr <= cur_addr;
            mem_wdata <= wdata;
            mem_wstrb <= wstrb;
            wr_id <= cur_id;
        end
    end

endmodule : axi3_mem_wr_stage

`default_nettype wire

/* axi3_mem_top.f */
common/axi3_pkg.sv
axi3_mem/axi3_mem_wr_stage.sv
axi3_mem/axi3_mem_rd_stage.sv
axi3_mem/axi3_mem_array.sv
axi3_mem/axi3_mem_resp_stage.sv
design/axi3_mem_top.sv
bench/axi3_mem_checker.sv
bench/axi3_mem_tb.sv

/* bench/axi3_mem_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module axi3_mem_checker #(
    parameter int DATA_BYTE_WID = 8,
    parameter int ID_WID = 4
) (
    input wire                        axi3_if,
    input wire                        srst,
    input wire                        arvalid,
    input wire                        arready,
    input wire axi3_pkg::len_t        arlen,
    input wire                        wready,
    input wire                        bvalid,
    input wire                        bready,
    input wire [ID_WID-1:0]           bid,
    input wire axi3_pkg::resp_t       bresp,
    input wire                        rvalid,
    input wire                        rready,
    input wire [DATA_BYTE_WID*8-1:0]  rdata,
    input wire [ID_WID-1:0]           rid,
    input wire                        rlast,
    input wire axi3_pkg::wr_state_t   wr_state
);

    int             fail_count = 0;
    axi3_pkg::len_t len_mem [16];
    logic [3:0]     ar_ptr;
    logic [3:0]     r_ptr;
    logic [3:0]     beat_cnt;

    // Burst lengths in AR order, consumed as R bursts finish
    always @(posedge axi3_if) begin
        if (srst) begin
            ar_ptr <= '0;
            r_ptr <= '0;
            beat_cnt <= '0;
        end else begin
            if (arvalid && arready) begin
                len_mem[ar_ptr] <= arlen;
                ar_ptr <= ar_ptr + 4'd1;
            end
            if (rvalid && rready) begin
                beat_cnt <= rlast ? 4'd0 : beat_cnt + 4'd1;
                r_ptr <= rlast ? r_ptr + 4'd1 : r_ptr;
            end
        end
    end

    b_hold: assert property (@(posedge axi3_if) disable iff (srst)
        bvalid && !bready |=> bvalid && $stable(bid) && $stable(bresp))
        else begin
            $error("B channel changed while waiting for bready");
            fail_count++;
        end

    r_hold: assert property (@(posedge axi3_if) disable iff (srst)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rid) && $stable(rlast))
        else begin
            $error("R channel changed while waiting for rready");
            fail_count++;
        end

    reset_state: assert property (@(posedge axi3_if)
        srst |=> !bvalid && !rvalid && !wready && wr_state == axi3_pkg::WR_IDLE)
        else begin
            $error("Outputs not inactive after reset");
            fail_count++;
        end

    rlast_end: assert property (@(posedge axi3_if) disable iff (srst)
        rvalid && rready |-> rlast == (beat_cnt == len_mem[r_ptr]))
        else begin
            $error("rlast does not match the burst length");
            fail_count++;
        end

endmodule : axi3_mem_checker

bind axi3_mem_top axi3_mem_checker #(
    .DATA_BYTE_WID (DATA_BYTE_WID),
    .ID_WID        (ID_WID)
) checker_i (
    .axi3_if  (axi3_if),
    .srst     (srst),
    .arvalid  (arvalid),
    .arready  (arready),
    .arlen    (arlen),
    .wready   (wready),
    .bvalid   (bvalid),
    .bready   (bready),
    .bid      (bid),
    .bresp    (bresp),
    .rvalid   (rvalid),
    .rready   (rready),
    .rdata    (rdata),
    .rid      (rid),
    .rlast    (rlast),
    .wr_state (wr_stage_i.state)
);

`default_nettype wire

/* bench/axi3_mem_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module axi3_mem_tb;

    localparam int ADDR_WID = 16;
    localparam int DATA_BYTE_WID = 8;
    localparam int ID_WID = 4;
    localparam int MEM_WORDS_LOG2 = 10;
    localparam int DATA_WID = DATA_BYTE_WID * 8;
    // Preloaded region, all later bursts stay inside it
    localparam int TEST_WORDS = 128;
    // Roughly 800 cycles of traffic, with a wide margin
    localparam int MAX_CYCLES = 4000;

    logic                  axi3_if;
    logic                  srst;
    logic                  awvalid;
    logic                  awready;
    logic [ADDR_WID-1:0]   awaddr;
    axi3_pkg::len_t        awlen;
    logic [ID_WID-1:0]     awid;
    logic                  wvalid;
    logic                  wready;
    logic [DATA_WID-1:0]   wdata;
    logic [DATA_BYTE_WID-1:0] wstrb;
    logic                  wlast;
    logic                  bvalid;
    logic                  bready;
    logic [ID_WID-1:0]     bid;
    axi3_pkg::resp_t       bresp;
    logic                  arvalid;
    logic                  arready;
    logic [ADDR_WID-1:0]   araddr;
    axi3_pkg::len_t        arlen;
    logic [ID_WID-1:0]     arid;
    logic                  rvalid;
    logic                  rready;
    logic [DATA_WID-1:0]   rdata;
    logic [ID_WID-1:0]     rid;
    logic                  rlast;
    axi3_pkg::resp_t       rresp;

    logic [7:0]            ref_mem [TEST_WORDS*DATA_BYTE_WID];
    int unsigned           exp_r_word [$];
    logic [ID_WID-1:0]     exp_r_id [$];
    logic                  exp_r_last [$];
    logic [ID_WID-1:0]     exp_b_id [$];
    integer                seed;
    int                    error_count = 0;
    int                    cycle_count = 0;
    logic                  bp_en = 1'b0;
    logic [31:0]           bp_rnd;
    string                 test_name = "reset";

    axi3_mem_top #(
        .ADDR_WID       (ADDR_WID),
        .DATA_BYTE_WID  (DATA_BYTE_WID),
        .ID_WID         (ID_WID),
        .MEM_WORDS_LOG2 (MEM_WORDS_LOG2)
    ) dut_i (.*);

    initial begin
        axi3_if = 1'b0;
        forever #5 axi3_if = ~axi3_if;
    end

    always @(posedge axi3_if) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: traffic did not drain within %0d cycles", MAX_CYCLES);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    // Random ready back-pressure on B and R
    always @(posedge axi3_if) begin
        #1;
        if (bp_en) begin
            bp_rnd = $random(seed);
            rready = bp_rnd[0];
            bready = bp_rnd[1];
        end else begin
            rready = 1'b1;
            bready = 1'b1;
        end
    end

    function automatic logic [DATA_WID-1:0] expected_word(input int unsigned word);
        logic [DATA_WID-1:0] w;
        for (int i = 0; i < DATA_BYTE_WID; i++) begin
            w[i*8 +: 8] = ref_mem[word*DATA_BYTE_WID + i];
        end
        return w;
    endfunction

    task automatic check(input string name, input logic [DATA_WID-1:0] expected,
                         input logic [DATA_WID-1:0] actual);
        if (actual !== expected) begin
            $display("ERROR %s: expected %h, actual %h", name, expected, actual);
            error_count++;
        end
    endtask

    // Handshakes sampled mid-cycle, where all signals are settled
    always @(negedge axi3_if) begin
        if (rvalid && rready) begin
            if (exp_r_word.size() == 0) begin
                $display("%s: R beat arrived with no read outstanding", test_name);
                error_count++;
            end else begin
                check({test_name, " rdata"}, expected_word(exp_r_word[0]), rdata);
                check({test_name, " rid"}, exp_r_id[0], rid);
                check({test_name, " rlast"}, exp_r_last[0], rlast);
                check({test_name, " rresp"}, axi3_pkg::RESP_OKAY, rresp);
                void'(exp_r_word.pop_front());
                void'(exp_r_id.pop_front());
                void'(exp_r_last.pop_front());
            end
        end
        if (bvalid && bready) begin
            if (exp_b_id.size() == 0) begin
                $display("%s: B response arrived with no write outstanding", test_name);
                error_count++;
            end else begin
                check({test_name, " bid"}, exp_b_id.pop_front(), bid);
                check({test_name, " bresp"}, axi3_pkg::RESP_OKAY, bresp);
            end
        end
    end

    task automatic next_cycle();
        @(posedge axi3_if);
        #1;
    endtask

    task automatic write_burst(input int unsigned word, input axi3_pkg::len_t len,
                               input logic [ID_WID-1:0] id, input logic full_strb);
        logic [31:0] rnd;
        awvalid = 1'b1;
        awaddr = ADDR_WID'(word * DATA_BYTE_WID);
        awlen = len;
        awid = id;
        exp_b_id.push_back(id);
        @(negedge axi3_if);
        while (!awready) @(negedge axi3_if);
        next_cycle();
        awvalid = 1'b0;
        for (int b = 0; b <= int'(len); b++) begin
            rnd = $random(seed);
            wvalid = 1'b1;
            wdata = {$random(seed), $random(seed)};
            wstrb = full_strb ? '1 : rnd[DATA_BYTE_WID-1:0];
            wlast = (b == int'(len));
            @(negedge axi3_if);
            while (!wready) @(negedge axi3_if);
            for (int i = 0; i < DATA_BYTE_WID; i++) begin
                if (wstrb[i]) begin
                    ref_mem[(word + b)*DATA_BYTE_WID + i] = wdata[i*8 +: 8];
                end
            end
            next_cycle();
        end
        wvalid = 1'b0;
        wlast = 1'b0;
    endtask

    task automatic read_burst(input int unsigned word, input axi3_pkg::len_t len,
                              input logic [ID_WID-1:0] id);
        arvalid = 1'b1;
        araddr = ADDR_WID'(word * DATA_BYTE_WID);
        arlen = len;
        arid = id;
        for (int b = 0; b <= int'(len); b++) begin
            exp_r_word.push_back(word + b);
            exp_r_id.push_back(id);
            exp_r_last.push_back(b == int'(len));
        end
        @(negedge axi3_if);
        while (!arready) @(negedge axi3_if);
        next_cycle();
        arvalid = 1'b0;
    endtask

    task automatic pick_burst(output axi3_pkg::len_t len, output int unsigned word);
        logic [31:0] rnd;
        rnd = $random(seed);
        len = rnd[3:0];
        word = rnd[31:8] % (TEST_WORDS - int'(len));
    endtask

    task automatic wait_drain();
        while (exp_r_word.size() != 0 || exp_b_id.size() != 0) begin
            next_cycle();
        end
    endtask

    initial begin
        axi3_pkg::len_t len;
        int unsigned word;
        int total_errors;
        seed = 32'he176;
        srst = 1'b1;
        awvalid = 1'b0;
        awaddr = '0;
        awlen = '0;
        awid = '0;
        wvalid = 1'b0;
        wdata = '0;
        wstrb = '0;
        wlast = 1'b0;
        bready = 1'b1;
        arvalid = 1'b0;
        araddr = '0;
        arlen = '0;
        arid = '0;
        rready = 1'b1;
        repeat (10) @(posedge axi3_if);
        #1;
        srst = 1'b0;

        check("reset bvalid", 0, bvalid);
        check("reset rvalid", 0, rvalid);
        check("reset wready", 0, wready);
        check("reset awready", 1, awready);
        check("reset arready", 1, arready);

        // Every byte of the test region gets a known value first
        test_name = "preload";
        for (int w = 0; w < TEST_WORDS; w += 16) begin
            write_burst(w, 4'd15, ID_WID'(w / 16), 1'b1);
        end
        wait_drain();

        test_name = "single";
        write_burst(40, 4'd0, 4'h3, 1'b1);
        wait_drain();
        read_burst(40, 4'd0, 4'h5);
        wait_drain();

        test_name = "incr";
        for (int k = 0; k < 8; k++) begin
            pick_burst(len, word);
            write_burst(word, len, ID_WID'(k), 1'b0);
            wait_drain();
            read_burst(word, len, ID_WID'(k + 8));
            wait_drain();
        end

        test_name = "ar_b2b";
        for (int k = 0; k < 6; k++) begin
            pick_burst(len, word);
            read_burst(word, len, ID_WID'(k + 10));
        end
        wait_drain();

        test_name = "backpressure";
        bp_en = 1'b1;
        for (int k = 0; k < 6; k++) begin
            pick_burst(len, word);
            write_burst(word, len, ID_WID'(k + 2), 1'b0);
        end
        wait_drain();
        for (int k = 0; k < 6; k++) begin
            pick_burst(len, word);
            read_burst(word, len, ID_WID'(15 - k));
        end
        wait_drain();
        bp_en = 1'b0;
        next_cycle();

        total_errors = error_count + dut_i.checker_i.fail_count;
        $display("Errors: %0d (compare %0d, assertion %0d)", total_errors, error_count,
                 dut_i.checker_i.fail_count);
        if (total_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule : axi3_mem_tb

`default_nettype wire

/* common/axi3_pkg.sv */
`default_nettype none

package axi3_pkg;

    // AXI3 response codes, only okay is ever driven
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_EXOKAY = 2'b01,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } resp_t;

    // Burst length minus one
    typedef logic [3:0] len_t;

    localparam int ADDR_Q_DEPTH = 4;
    localparam int RESP_Q_DEPTH = 4;

    typedef enum logic [1:0] {
        WR_IDLE  = 2'b00,
        WR_BURST = 2'b01
    } wr_state_t;

endpackage : axi3_pkg

`default_nettype wire

/* design/axi3_mem_top.sv */
`timescale 1ns/1ps
`default_nettype none

module axi3_mem_top #(
    parameter int ADDR_WID = 16,
    parameter int DATA_BYTE_WID = 8,
    parameter int ID_WID = 4,
    parameter int MEM_WORDS_LOG2 = 10
) (
    input  wire                          axi3_if,
    input  wire                          srst,
    input  wire                          awvalid,
    output logic                         awready,
    input  wire [ADDR_WID-1:0]           awaddr,
    input  wire axi3_pkg::len_t          awlen,
    input  wire [ID_WID-1:0]             awid,
    input  wire                          wvalid,
    output logic                         wready,
    input  wire [DATA_BYTE_WID*8-1:0]    wdata,
    input  wire [DATA_BYTE_WID-1:0]      wstrb,
    input  wire                          wlast,
    output logic                         bvalid,
    input  wire                          bready,
    output logic [ID_WID-1:0]            bid,
    output axi3_pkg::resp_t              bresp,
    input  wire                          arvalid,
    output logic                         arready,
    input  wire [ADDR_WID-1:0]           araddr,
    input  wire axi3_pkg::len_t          arlen,
    input  wire [ID_WID-1:0]             arid,
    output logic                         rvalid,
    input  wire                          rready,
    output logic [DATA_BYTE_WID*8-1:0]   rdata,
    output logic [ID_WID-1:0]            rid,
    output logic                         rlast,
    output axi3_pkg::resp_t              rresp
);

    logic                       mem_we;
    logic [MEM_WORDS_LOG2-1:0]  mem_waddr;
    logic [DATA_BYTE_WID*8-1:0] mem_wdata;
    logic [DATA_BYTE_WID-1:0]   mem_wstrb;
    logic                       wr_done;
    logic [ID_WID-1:0]          wr_id;
    logic                       b_room;

    logic                       mem_re;
    logic [MEM_WORDS_LOG2-1:0]  mem_raddr;
    logic [ID_WID-1:0]          rd_id;
    logic                       rd_last;
    logic                       r_room;

    logic                       rd_valid;
    logic [DATA_BYTE_WID*8-1:0] rd_data;
    logic [ID_WID-1:0]          rd_id_q;
    logic                       rd_last_q;

    axi3_mem_wr_stage #(
        .ADDR_WID       (ADDR_WID),
        .DATA_BYTE_WID  (DATA_BYTE_WID),
        .ID_WID         (ID_WID),
        .MEM_WORDS_LOG2 (MEM_WORDS_LOG2)
    ) wr_stage_i (
        .axi3_if   (axi3_if),
        .srst      (srst),
        .awvalid   (awvalid),
        .awready   (awready),
        .awaddr    (awaddr),
        .awlen     (awlen),
        .awid      (awid),
        .wvalid    (wvalid),
        .wready    (wready),
        .wdata     (wdata),
        .wstrb     (wstrb),
        .wlast     (wlast),
        .b_room    (b_room),
        .mem_we    (mem_we),
        .mem_waddr (mem_waddr),
        .mem_wdata (mem_wdata),
        .mem_wstrb (mem_wstrb),
        .wr_done   (wr_done),
        .wr_id     (wr_id)
    );

    axi3_mem_rd_stage #(
        .ADDR_WID       (ADDR_WID),
        .DATA_BYTE_WID  (DATA_BYTE_WID),
        .ID_WID         (ID_WID),
        .MEM_WORDS_LOG2 (MEM_WORDS_LOG2)
    ) rd_stage_i (
        .axi3_if   (axi3_if),
        .srst      (srst),
        .arvalid   (arvalid),
        .arready   (arready),
        .araddr    (araddr),
        .arlen     (arlen),
        .arid      (arid),
        .r_room    (r_room),
        .mem_re    (mem_re),
        .mem_raddr (mem_raddr),
        .rd_id     (rd_id),
        .rd_last   (rd_last)
    );

    axi3_mem_array #(
        .DATA_BYTE_WID  (DATA_BYTE_WID),
        .ID_WID         (ID_WID),
        .MEM_WORDS_LOG2 (MEM_WORDS_LOG2)
    ) array_i (
        .axi3_if   (axi3_if),
        .srst      (srst),
        .mem_we    (mem_we),
        .mem_waddr (mem_waddr),
        .mem_wdata (mem_wdata),
        .mem_wstrb (mem_wstrb),
        .mem_re    (mem_re),
        .mem_raddr (mem_raddr),
        .rd_id     (rd_id),
        .rd_last   (rd_last),
        .rd_valid  (rd_valid),
        .rd_data   (rd_data),
        .rd_id_q   (rd_id_q),
        .rd_last_q (rd_last_q)
    );

    axi3_mem_resp_stage #(
        .DATA_BYTE_WID (DATA_BYTE_WID),
        .ID_WID        (ID_WID)
    ) resp_stage_i (
        .axi3_if   (axi3_if),
        .srst      (srst),
        .wr_done   (wr_done),
        .wr_id     (wr_id),
        .rd_valid  (rd_valid),
        .rd_data   (rd_data),
        .rd_id_q   (rd_id_q),
        .rd_last_q (rd_last_q),
        .b_room    (b_room),
        .r_room    (r_room),
        .bvalid    (bvalid),
        .bready    (bready),
        .bid       (bid),
        .bresp     (bresp),
        .rvalid    (rvalid),
        .rready    (rready),
        .rdata     (rdata),
        .rid       (rid),
        .rlast     (rlast),
        .rresp     (rresp)
    );

endmodule : axi3_mem_top

`default_nettype wire
